// File: gpio_bridge_top.f
logic/gpio_bus_pkg.sv
logic/gpio_req_if.sv
logic/bus_capture.sv
logic/gpio_port_bank.sv
logic/readback_reg.sv
logic/gpio_bridge_top.sv
verification/gpio_bridge_tb.sv

// File: logic/bus_capture.sv
/*
 * Stage 1 of the bridge. Qualifies host strobes with chip select and
 * registers them together with the split address and the write data.
 */

`timescale 1ns/1ps

module bus_capture (
	input  logic                    clk_low,
	input  logic                    arst_n,
	input  logic                    chip_sel,
	input  logic                    write_strobe,
	input  logic                    read_strobe,
	input  gpio_bus_pkg::word_addr_t bus_addr,
	input  gpio_bus_pkg::bus_data_t  bus_wdata,
	gpio_req_if.capture             req
);
	import gpio_bus_pkg::*;

	logic wr_acc;  // write seen under chip select
	logic rd_acc;  // read seen under chip select

	assign wr_acc = chip_sel & write_strobe;
	assign rd_acc = chip_sel & read_strobe;

	// ==============================
	// strobes, control state
	// ==============================
	always_ff @(posedge clk_low or negedge arst_n) begin
		if (!arst_n) begin
			req.req_wr <= 1'b0;
			req.req_rd <= 1'b0;
		end else begin
			req.req_wr <= wr_acc;   // one cycle only, no hold
			req.req_rd <= rd_acc;
		end
	end

	// ==============================
	// payload, taken every cycle
	// ==============================
	always_ff @(posedge clk_low) begin
		req.req_kind  <= bus_addr[KIND_WIDTH-1:0];           // kind field
		req.req_port  <= bus_addr[ADDR_WIDTH-1:KIND_WIDTH];  // port field
		req.req_wdata <= bus_wdata;
	end

	// host never issues read and write in the same selected cycle
	a_no_rw_overlap: assert property (
		@(posedge clk_low) disable iff (!arst_n)
		chip_sel |-> !(write_strobe && read_strobe)
	) else $error("bus_capture: read and write strobes together under chip_sel");

endmodule

// File: logic/gpio_bridge_top.sv
/*
 * Top level of the host-bus GPIO bridge. Wires the capture, port bank and
 * readback stages; all ports are plain and run on clk_low.
 */

`timescale 1ns/1ps

module gpio_bridge_top #(
	parameter int NUM_PORTS  = 2,
	parameter int PORT_WIDTH = 32
) (
	input  logic                            clk_low,
	input  logic                            arst_n,
	// host bus
	input  logic                            chip_sel,
	input  logic                            write_strobe,
	input  logic                            read_strobe,
	input  gpio_bus_pkg::word_addr_t        bus_addr,
	input  gpio_bus_pkg::bus_data_t         bus_wdata,
	output gpio_bus_pkg::bus_data_t         bus_rdata,
	output logic                            read_valid,
	// gpio pins, port p in slice p
	output logic [NUM_PORTS*PORT_WIDTH-1:0] pin_out,
	output logic [NUM_PORTS*PORT_WIDTH-1:0] pin_oe,
	input  logic [NUM_PORTS*PORT_WIDTH-1:0] pin_in
);
	import gpio_bus_pkg::*;

	gpio_req_if u_req_if ();   // stage 1 to stage 2

	logic      rd_pend;   // stage 2 to stage 3
	bus_data_t rd_word;

	// ==============================
	// pipeline stages
	// ==============================
	bus_capture u_bus_capture (
		.clk_low      (clk_low),
		.arst_n       (arst_n),
		.chip_sel     (chip_sel),
		.write_strobe (write_strobe),
		.read_strobe  (read_strobe),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.req          (u_req_if.capture)
	);

	gpio_port_bank #(
		.NUM_PORTS  (NUM_PORTS),
		.PORT_WIDTH (PORT_WIDTH)
	) u_gpio_port_bank (
		.clk_low (clk_low),
		.arst_n  (arst_n),
		.req     (u_req_if.decode),
		.pin_in  (pin_in),
		.pin_out (pin_out),
		.pin_oe  (pin_oe),
		.rd_pend (rd_pend),
		.rd_word (rd_word)
	);

	readback_reg u_readback_reg (
		.clk_low    (clk_low),
		.arst_n     (arst_n),
		.rd_pend    (rd_pend),
		.rd_word    (rd_word),
		.bus_rdata  (bus_rdata),
		.read_valid (read_valid)
	);

endmodule

// File: logic/gpio_bus_pkg.sv
/*
 * Shared widths, address layout and register kind codes for the host-bus
 * GPIO block. Every module pulls what it needs from here.
 */

package gpio_bus_pkg;

	// ==============================
	// host bus widths
	// ==============================
	localparam int BUS_WIDTH  = 32;      // host data bus
	localparam int ADDR_WIDTH = 14;      // word address, byte address[15:2]

	// ==============================
	// word address layout
	// ==============================
	// low bits pick the register kind, the rest pick the port
	localparam int KIND_WIDTH     = 2;
	localparam int PORT_NUM_WIDTH = ADDR_WIDTH - KIND_WIDTH;   // 12 bits

	typedef logic [BUS_WIDTH-1:0]      bus_data_t;    // one bus word
	typedef logic [ADDR_WIDTH-1:0]     word_addr_t;   // host word address
	typedef logic [KIND_WIDTH-1:0]     reg_kind_t;    // register kind field
	typedef logic [PORT_NUM_WIDTH-1:0] port_num_t;    // port number field

	// ==============================
	// register kind codes
	// ==============================
	localparam reg_kind_t REG_OUT = 2'd0;  // output data
	localparam reg_kind_t REG_DIR = 2'd1;  // direction, 1 drives the pin
	localparam reg_kind_t REG_IN  = 2'd2;  // synced pin input, read only
	// code 3 left unmapped, reads 0 and ignores writes

endpackage

// File: logic/gpio_port_bank.sv
/*
 * Stage 2 of the bridge. Decodes the captured request, holds the per-port
 * output and direction registers, double-flops the pin inputs and latches
 * the selected read word for the readback stage.
 */

`timescale 1ns/1ps

module gpio_port_bank #(
	parameter int NUM_PORTS  = 2,
	parameter int PORT_WIDTH = 32    // at most the bus width
) (
	input  logic                          clk_low,
	input  logic                          arst_n,
	gpio_req_if.decode                    req,
	input  logic [NUM_PORTS*PORT_WIDTH-1:0] pin_in,
	output logic [NUM_PORTS*PORT_WIDTH-1:0] pin_out,
	output logic [NUM_PORTS*PORT_WIDTH-1:0] pin_oe,
	output logic                          rd_pend,
	output gpio_bus_pkg::bus_data_t       rd_word
);
	import gpio_bus_pkg::*;

	logic [PORT_WIDTH-1:0] out_reg [NUM_PORTS];   // output data per port
	logic [PORT_WIDTH-1:0] dir_reg [NUM_PORTS];   // output enable per port
	logic [NUM_PORTS*PORT_WIDTH-1:0] pin_meta;    // first sync flop
	logic [NUM_PORTS*PORT_WIDTH-1:0] pin_sync;    // second sync flop, REG_IN value

	logic [NUM_PORTS-1:0] port_sel;  // one-hot port match
	logic                 port_hit;  // port number in range
	logic                 wr_hit;    // write lands on a writable register
	bus_data_t            rd_sel;    // read mux output

	// ==============================
	// decode
	// ==============================
	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_sel[p] = (req.req_port == port_num_t'(p));
		end
	end

	assign port_hit = |port_sel;
	// REG_IN is read only, code 3 unmapped
	assign wr_hit = req.req_wr && port_hit &&
		(req.req_kind == REG_OUT || req.req_kind == REG_DIR);

	// ==============================
	// port registers and pins
	// ==============================
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		always_ff @(posedge clk_low or negedge arst_n) begin
			if (!arst_n) begin
				out_reg[p] <= '0;
				dir_reg[p] <= '0;
			end else if (wr_hit && port_sel[p]) begin
				if (req.req_kind == REG_OUT)
					out_reg[p] <= req.req_wdata[PORT_WIDTH-1:0];  // low bits only
				else
					dir_reg[p] <= req.req_wdata[PORT_WIDTH-1:0];
			end
		end

		assign pin_out[p*PORT_WIDTH +: PORT_WIDTH] = out_reg[p];
		assign pin_oe[p*PORT_WIDTH +: PORT_WIDTH]  = dir_reg[p];
	end

	// two-flop synchronizer on the raw pins
	always_ff @(posedge clk_low or negedge arst_n) begin
		if (!arst_n) begin
			pin_meta <= '0;
			pin_sync <= '0;
		end else begin
			pin_meta <= pin_in;
			pin_sync <= pin_meta;
		end
	end

	// ==============================
	// read select
	// ==============================
	always_comb begin
		rd_sel = '0;                      // miss reads zero
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (port_sel[p]) begin
				case (req.req_kind)
					REG_OUT: rd_sel = bus_data_t'(out_reg[p]);   // upper bits zero
					REG_DIR: rd_sel = bus_data_t'(dir_reg[p]);
					REG_IN:  rd_sel = bus_data_t'(pin_sync[p*PORT_WIDTH +: PORT_WIDTH]);
					default: rd_sel = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_low or negedge arst_n) begin
		if (!arst_n)
			rd_pend <= 1'b0;
		else
			rd_pend <= req.req_rd;       // marks a word for stage 3
	end

	always_ff @(posedge clk_low) begin
		if (req.req_rd)
			rd_word <= rd_sel;
	end

	// a write past the last port leaves every pin register alone
	a_wr_in_range: assert property (
		@(posedge clk_low) disable iff (!arst_n)
		(req.req_wr && req.req_port >= port_num_t'(NUM_PORTS))
			|=> ($stable(pin_out) && $stable(pin_oe))
	) else $error("gpio_port_bank: write outside the port range changed the pins");

endmodule

// File: logic/gpio_req_if.sv
/*
 * One captured host request, handed from the capture stage to the decode
 * stage. Valid for a single cycle, no handshake.
 */

`timescale 1ns/1ps

interface gpio_req_if;
	import gpio_bus_pkg::*;

	logic      req_wr;     // write accepted this cycle
	logic      req_rd;     // read accepted this cycle
	reg_kind_t req_kind;   // register kind from addr low bits
	port_num_t req_port;   // port number from addr high bits
	bus_data_t req_wdata;  // write payload

	// stage 1 side
	modport capture (
		output req_wr, req_rd, req_kind, req_port, req_wdata
	);

	// stage 2 side
	modport decode (
		input req_wr, req_rd, req_kind, req_port, req_wdata
	);

endinterface

// File: logic/readback_reg.sv
/*
 * Stage 3 of the bridge. Holds the read data steady on the host bus between
 * reads and pulses read_valid at the end of the fixed read latency.
 */

`timescale 1ns/1ps

module readback_reg (
	input  logic                    clk_low,
	input  logic                    arst_n,
	input  logic                    rd_pend,
	input  gpio_bus_pkg::bus_data_t rd_word,
	output gpio_bus_pkg::bus_data_t bus_rdata,
	output logic                    read_valid
);
	import gpio_bus_pkg::*;

	// ==============================
	// host-facing read data
	// ==============================
	always_ff @(posedge clk_low or negedge arst_n) begin
		if (!arst_n) begin
			bus_rdata  <= '0;
			read_valid <= 1'b0;
		end else begin
			read_valid <= rd_pend;       // one cycle per pending read
			if (rd_pend)
				bus_rdata <= rd_word;    // otherwise hold last word
		end
	end

	// every pending read brings a defined word from stage 2
	a_rd_word_known: assert property (
		@(posedge clk_low) disable iff (!arst_n)
		rd_pend |-> !$isunknown(rd_word)
	) else $error("readback_reg: pending read with unknown rd_word");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the GPIO bridge testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --assert -Wno-fatal \
	-f gpio_bridge_top.f \
	--top-module gpio_bridge_tb \
	-Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vgpio_bridge_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// File: verification/gpio_bridge_patterns.txt
// columns: op addr data expect (hex), op 1 wr 2 rd 3 pins 4 chk 5 rnd 6 cs-low 7 burst
// op 4 checks pin_out when addr is 0 and pin_oe when addr is 1
1 0 a5a51234 0
4 0 0 00000000a5a51234
1 5 ffff0000 0
4 1 0 ffff000000000000
1 4 0badcafe 0
4 0 0 0badcafea5a51234
1 1 0000ffff 0
4 1 0 ffff00000000ffff
2 0 0 a5a51234
2 5 0 ffff0000
2 4 0 0badcafe
2 1 0 0000ffff
3 0 12345678 0
3 1 87654321 0
2 2 0 12345678
2 6 0 87654321
6 0 deadbeef 0
1 3 11111111 0
1 2 22222222 0
1 8 33333333 0
1 9 44444444 0
4 0 0 0badcafea5a51234
4 1 0 ffff00000000ffff
2 3 0 0
2 8 0 0
2 0 0 a5a51234
5 0 0 0
5 5 0 0
7 4 0 0
7 0 0 0

// File: verification/gpio_bridge_tb.sv
/*
 * Testbench for the host-bus GPIO bridge. Reads operations from the pattern
 * file, drives the host bus and pins on the falling edge, checks pins and
 * read data against the file and a register model.
 */

`timescale 1ns/1ps

module gpio_bridge_tb;
	import gpio_bus_pkg::*;

	localparam int NUM_PORTS  = 2;
	localparam int PORT_WIDTH = 32;
	localparam int PIN_W      = NUM_PORTS * PORT_WIDTH;
	localparam int CLK_PERIOD = 100;    // ns
	localparam int TIMEOUT    = 20;     // cycles per wait
	localparam int MAX_OPS    = 64;

	typedef logic [PIN_W-1:0] pins_t;

	logic       clk_low;
	logic       arst_n;
	logic       chip_sel;
	logic       write_strobe;
	logic       read_strobe;
	word_addr_t bus_addr;
	bus_data_t  bus_wdata;
	bus_data_t  bus_rdata;
	logic       read_valid;
	pins_t      pin_out;
	pins_t      pin_oe;
	pins_t      pin_in;

	logic [63:0] pat [0:4*MAX_OPS-1];   // op, addr, data, expect per entry
	bus_data_t   model_out [NUM_PORTS];
	bus_data_t   model_dir [NUM_PORTS];
	bus_data_t   model_in  [NUM_PORTS];
	logic [31:0] lfsr;
	int          errors;
	int          tests;
	int          test_err;

	gpio_bridge_top #(
		.NUM_PORTS  (NUM_PORTS),
		.PORT_WIDTH (PORT_WIDTH)
	) u_gpio_bridge_top (
		.clk_low      (clk_low),
		.arst_n       (arst_n),
		.chip_sel     (chip_sel),
		.write_strobe (write_strobe),
		.read_strobe  (read_strobe),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.bus_rdata    (bus_rdata),
		.read_valid   (read_valid),
		.pin_out      (pin_out),
		.pin_oe       (pin_oe),
		.pin_in       (pin_in)
	);

	initial begin
		clk_low = 1'b0;
		forever #(CLK_PERIOD/2) clk_low = ~clk_low;
	end

	// ==============================
	// random data and model
	// ==============================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois form
	endfunction

	task automatic next_random(output bus_data_t w);
		for (int i = 0; i < BUS_WIDTH; i++) begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];     // one step per bit
		end
	endtask

	function automatic bus_data_t predict_read(input word_addr_t a);
		int        port;
		reg_kind_t kind;
		port = int'(a[ADDR_WIDTH-1:KIND_WIDTH]);
		kind = a[KIND_WIDTH-1:0];
		if (port >= NUM_PORTS)
			return '0;          // miss
		case (kind)
			REG_OUT: return model_out[port];
			REG_DIR: return model_dir[port];
			REG_IN:  return model_in[port];
			default: return '0;
		endcase
	endfunction

	task automatic update_model(input word_addr_t a, input bus_data_t d);
		int        port;
		reg_kind_t kind;
		port = int'(a[ADDR_WIDTH-1:KIND_WIDTH]);
		kind = a[KIND_WIDTH-1:0];
		if (port < NUM_PORTS && kind == REG_OUT)
			model_out[port] = d;
		else if (port < NUM_PORTS && kind == REG_DIR)
			model_dir[port] = d;
	endtask

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_word(input string name, input bus_data_t exp, input bus_data_t act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_pins(input string name, input pins_t exp, input pins_t act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
			errors++;
			test_err++;
		end
	endtask

	// ==============================
	// bus tasks
	// ==============================
	task automatic bus_write(input word_addr_t a, input bus_data_t d, input logic cs);
		@(negedge clk_low);
		chip_sel     = cs;
		write_strobe = 1'b1;
		bus_addr     = a;
		bus_wdata    = d;
		@(negedge clk_low);
		chip_sel     = 1'b0;
		write_strobe = 1'b0;
	endtask

	// counts falling edges until read_valid shows up
	task automatic wait_read_valid(output int cycles);
		cycles = 0;
		while (read_valid !== 1'b1 && cycles < TIMEOUT) begin
			@(negedge clk_low);
			cycles++;
		end
		if (read_valid !== 1'b1) begin
			$display("timeout at %0t ns: read_valid never came after a read", $time);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_latency(input int cycles, input int exp);
		if (cycles != exp) begin
			$display("read latency wrong at %0t ns: read_valid after %0d cycles, not %0d",
				$time, cycles, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic bus_read(input word_addr_t a, input bus_data_t exp);
		int n;
		@(negedge clk_low);
		chip_sel    = 1'b1;
		read_strobe = 1'b1;
		bus_addr    = a;
		@(negedge clk_low);
		chip_sel    = 1'b0;
		read_strobe = 1'b0;
		wait_read_valid(n);
		check_latency(n, 2);   // valid after edge 2
		check_word("bus_rdata", exp, bus_rdata);
	endtask

	// random write, then a read of the same register on the next cycle
	task automatic write_then_read(input word_addr_t a);
		bus_data_t d;
		int        n;
		next_random(d);
		@(negedge clk_low);
		chip_sel     = 1'b1;
		write_strobe = 1'b1;
		bus_addr     = a;
		bus_wdata    = d;
		update_model(a, d);
		@(negedge clk_low);
		write_strobe = 1'b0;
		read_strobe  = 1'b1;
		@(negedge clk_low);
		chip_sel     = 1'b0;
		read_strobe  = 1'b0;
		wait_read_valid(n);
		check_latency(n, 2);
		check_word("bus_rdata", predict_read(a), bus_rdata);
	endtask

	// three reads on consecutive cycles, all in flight together
	task automatic read_burst(input word_addr_t a);
		bus_data_t exp [3];
		int        n;
		for (int i = 0; i < 3; i++)
			exp[i] = predict_read(a + word_addr_t'(i));
		for (int i = 0; i < 3; i++) begin
			@(negedge clk_low);
			chip_sel    = 1'b1;
			read_strobe = 1'b1;
			bus_addr    = a + word_addr_t'(i);
		end
		@(negedge clk_low);
		chip_sel    = 1'b0;
		read_strobe = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (i > 0)
				@(negedge clk_low);
			wait_read_valid(n);
			check_latency(n, 0);   // pulses back to back
			check_word("bus_rdata", exp[i], bus_rdata);
		end
		@(negedge clk_low);
		check_flag("read_valid", 1'b0, read_valid);   // one pulse per read
	endtask

	task automatic drive_pins(input int port, input bus_data_t val);
		@(negedge clk_low);
		pin_in[port*PORT_WIDTH +: PORT_WIDTH] = val[PORT_WIDTH-1:0];
		model_in[port] = val;
		repeat (3) @(negedge clk_low);   // through the synchronizer
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		logic [63:0] op;
		word_addr_t  addr;
		bus_data_t   data;
		logic [63:0] expect_val;
		int          i;

		arst_n       = 1'b0;
		chip_sel     = 1'b0;
		write_strobe = 1'b0;
		read_strobe  = 1'b0;
		bus_addr     = '0;
		bus_wdata    = '0;
		pin_in       = '0;
		lfsr         = 32'hbbc7502b;
		errors       = 0;
		tests        = 0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			model_out[p] = '0;
			model_dir[p] = '0;
			model_in[p]  = '0;
		end
		for (int k = 0; k < 4*MAX_OPS; k++)
			pat[k] = '0;     // op 0 ends the list
		$readmemh("verification/gpio_bridge_patterns.txt", pat);

		repeat (2) @(posedge clk_low);
		@(negedge clk_low);
		arst_n = 1'b1;

		// reset values, no stray read_valid
		test_err = 0;
		tests++;
		check_pins("pin_out", '0, pin_out);
		check_pins("pin_oe", '0, pin_oe);
		check_word("bus_rdata", '0, bus_rdata);
		repeat (3) begin
			@(negedge clk_low);
			check_flag("read_valid", 1'b0, read_valid);
		end
		$display("test %0d reset: %s", tests, test_err == 0 ? "ok" : "failed");

		i = 0;
		while (i < MAX_OPS && pat[4*i] != 64'd0) begin
			op         = pat[4*i];
			addr       = word_addr_t'(pat[4*i+1]);
			data       = bus_data_t'(pat[4*i+2]);
			expect_val = pat[4*i+3];
			test_err   = 0;
			tests++;
			case (op)
				64'd1: begin
					bus_write(addr, data, 1'b1);
					update_model(addr, data);
				end
				64'd2: bus_read(addr, bus_data_t'(expect_val));
				64'd3: drive_pins(int'(addr), data);
				64'd4: begin
					@(negedge clk_low);
					if (addr == '0)
						check_pins("pin_out", pins_t'(expect_val), pin_out);
					else
						check_pins("pin_oe", pins_t'(expect_val), pin_oe);
				end
				64'd5: write_then_read(addr);
				64'd6: bus_write(addr, data, 1'b0);   // chip_sel low, ignored
				64'd7: read_burst(addr);
				default: begin
					$display("pattern line %0d has unknown operation %0d", i, op);
					errors++;
					test_err++;
				end
			endcase
			$display("test %0d op %0d addr %h: %s", tests, op, addr,
				test_err == 0 ? "ok" : "failed");
			i++;
		end

		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
